// ==== design/button_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_sampler import led_pkg::*; #(
    parameter int TICK_CYCLES = TICK_CYCLES_DEFAULT
) (
    input  logic         clk_33,
    input  logic         nrst,
    input  logic         color_button,
    input  logic         demo_button,
    output pattern_cmd_t cmd
);

    // Two-flop synchronisers, index 1 is the safe output
    logic [1:0] color_sync;
    logic [1:0] demo_sync;

    logic [$clog2(TICK_CYCLES)-1:0] tick_cnt;
    logic                           tick_wrap;

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            color_sync <= '0;
            demo_sync  <= '0;
        end else begin
            color_sync <= {color_sync[0], color_button};
            demo_sync  <= {demo_sync[0], demo_button};
        end
    end

    assign tick_wrap = (tick_cnt == $bits(tick_cnt)'(TICK_CYCLES - 1));

    // Free running slow tick
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            tick_cnt <= '0;
        end else if (tick_wrap) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // A held button is only acted on once per tick
    always_comb begin
        cmd.color_step  = tick_wrap && color_sync[1];
        cmd.demo_toggle = tick_wrap && demo_sync[1];
    end

    // Requests stay single-cycle pulses whatever the button does
    a_cmd_pulse: assert property (
        @(posedge clk_33) disable iff (!nrst)
        (cmd.color_step || cmd.demo_toggle) |=> !(cmd.color_step || cmd.demo_toggle)
    );

endmodule

`default_nettype wire

// ==== design/driver_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_controller import led_pkg::*; (
    input  logic       clk_33,
    input  logic       nrst,
    input  lane_word_t data,
    output logic       driver_ready,
    output panel_bus_t panel
);

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_SHIFT,
        ST_LATCH,
        ST_BLANK
    } state_t;

    state_t state;

    // Grayscale bit within the current word
    logic [$clog2(GRAY_BITS)-1:0]       bit_cnt;
    // High on the second cycle of each serial bit
    logic                               sclk_hi;
    logic [$clog2(WORDS_PER_FRAME)-1:0] word_cnt;
    logic [$clog2(BLANK_CYCLES)-1:0]    blank_cnt;

    // Colour bits being serialised
    lane_word_t word_q;

    logic last_bit;
    logic last_word;
    logic last_blank;

    assign last_bit   = (bit_cnt == $bits(bit_cnt)'(GRAY_BITS - 1));
    assign last_word  = (word_cnt == $bits(word_cnt)'(WORDS_PER_FRAME - 1));
    assign last_blank = (blank_cnt == $bits(blank_cnt)'(BLANK_CYCLES - 1));

    // Reset parks in the last blanking cycle so the first LOAD
    // follows straight after release
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            state     <= ST_BLANK;
            bit_cnt   <= '0;
            sclk_hi   <= 1'b0;
            word_cnt  <= '0;
            blank_cnt <= $bits(blank_cnt)'(BLANK_CYCLES - 1);
        end else begin
            case (state)
                ST_LOAD: begin
                    state   <= ST_SHIFT;
                    bit_cnt <= '0;
                    sclk_hi <= 1'b0;
                end
                ST_SHIFT: begin
                    sclk_hi <= !sclk_hi;
                    if (sclk_hi) begin
                        if (last_bit) begin
                            bit_cnt <= '0;
                            if (last_word) begin
                                word_cnt <= '0;
                                state    <= ST_LATCH;
                            end else begin
                                word_cnt <= word_cnt + 1'b1;
                                state    <= ST_LOAD;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_LATCH: begin
                    blank_cnt <= '0;
                    state     <= ST_BLANK;
                end
                ST_BLANK: begin
                    if (last_blank) begin
                        state <= ST_LOAD;
                    end else begin
                        blank_cnt <= blank_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_BLANK;
                end
            endcase
        end
    end

    // Word capture on the edge where the emulator moves on
    always_ff @(posedge clk_33) begin
        if (state == ST_LOAD) begin
            word_q <= data;
        end
    end

    assign driver_ready = (state == ST_LOAD);

    // Each lane bit repeats for the whole grayscale word
    always_comb begin
        panel.sclk  = (state == ST_SHIFT) && sclk_hi;
        panel.latch = (state == ST_LATCH);
        panel.blank = (state == ST_BLANK);
        panel.sdi   = (state == ST_SHIFT) ? word_q : '0;
    end

    a_latch_single: assert property (
        @(posedge clk_33) disable iff (!nrst)
        panel.latch |=> !panel.latch && panel.blank
    );

    a_no_sclk_in_blank: assert property (
        @(posedge clk_33) disable iff (!nrst)
        !(panel.sclk && panel.blank)
    );

    // The word taken on a request is the one that the lanes carry next
    a_ready_in_load: assert property (
        @(posedge clk_33) disable iff (!nrst)
        driver_ready |=> !driver_ready && !panel.sclk && (panel.sdi == $past(data))
    );

endmodule

`default_nettype wire

// ==== design/framebuffer_emulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module framebuffer_emulator import led_pkg::*; (
    input  logic         clk_33,
    input  logic         nrst,
    input  pattern_cmd_t cmd,
    input  logic         driver_ready,
    output lane_word_t   data
);

    // Displayed colour, 0 blue, 1 green, 2 red
    logic [1:0] color_sel;
    // 0 for a solid colour, 1 for the RGB stripe
    logic       demo_mode;
    // Colour bit being requested by the controller
    logic [1:0] bit_idx;
    // LED position along the chain, modulo 3
    logic [1:0] led_phase;

    logic [2:0] phase_sum;
    logic [1:0] stripe_idx;
    logic       lit;

    // Pattern selection from the buttons
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            color_sel <= '0;
            demo_mode <= 1'b0;
        end else begin
            if (cmd.color_step) begin
                if (color_sel == 2'(NUM_COLORS - 1)) begin
                    color_sel <= '0;
                end else begin
                    color_sel <= color_sel + 1'b1;
                end
            end
            if (cmd.demo_toggle) begin
                demo_mode <= !demo_mode;
            end
        end
    end

    // Step to the next word as the controller takes the current one
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            bit_idx   <= '0;
            led_phase <= '0;
        end else if (driver_ready) begin
            if (bit_idx == 2'(NUM_COLORS - 1)) begin
                bit_idx <= '0;
                // Keeps running across frames on purpose
                if (led_phase == 2'(NUM_COLORS - 1)) begin
                    led_phase <= '0;
                end else begin
                    led_phase <= led_phase + 1'b1;
                end
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    // (led_phase + color_sel) mod 3 without a divider
    always_comb begin
        phase_sum = {1'b0, led_phase} + {1'b0, color_sel};
        if (phase_sum >= 3'(NUM_COLORS)) begin
            stripe_idx = 2'(phase_sum - 3'(NUM_COLORS));
        end else begin
            stripe_idx = phase_sum[1:0];
        end
    end

    always_comb begin
        if (demo_mode) begin
            lit = (bit_idx == stripe_idx);
        end else begin
            lit = (bit_idx == color_sel);
        end
        data = lit ? '1 : '0;
    end

    a_bit_idx_range: assert property (
        @(posedge clk_33) disable iff (!nrst) bit_idx != 2'd3
    );
    a_led_phase_range: assert property (
        @(posedge clk_33) disable iff (!nrst) led_phase != 2'd3
    );
    a_color_sel_range: assert property (
        @(posedge clk_33) disable iff (!nrst) color_sel != 2'd3
    );

endmodule

`default_nettype wire

// ==== design/led_panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_top import led_pkg::*; #(
    parameter int TICK_CYCLES = TICK_CYCLES_DEFAULT
) (
    input  logic       clk_33,
    input  logic       nrst,
    input  logic       color_button,
    input  logic       demo_button,
    output panel_bus_t panel
);

    pattern_cmd_t cmd;
    lane_word_t   data;
    logic         driver_ready;

    // Buttons to pattern requests
    button_sampler #(
        .TICK_CYCLES (TICK_CYCLES)
    ) sampler0 (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .color_button (color_button),
        .demo_button  (demo_button),
        .cmd          (cmd)
    );

    // Test pattern source standing in for frame memory
    framebuffer_emulator emulator0 (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .cmd          (cmd),
        .driver_ready (driver_ready),
        .data         (data)
    );

    driver_controller controller0 (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .data         (data),
        .driver_ready (driver_ready),
        .panel        (panel)
    );

endmodule

`default_nettype wire

// ==== design/led_pkg.sv ====
`default_nettype none

package led_pkg;

    // Panel geometry
    localparam int NUM_LANES     = 30;
    localparam int LEDS_PER_LANE = 4;
    // Colour bits per LED, sent in the order blue (0), green (1), red (2)
    localparam int NUM_COLORS    = 3;

    // Driver chip timing
    // Grayscale word width of the drivers (poker mode)
    localparam int GRAY_BITS       = 9;
    localparam int BLANK_CYCLES    = 72;
    localparam int WORDS_PER_FRAME = NUM_COLORS * LEDS_PER_LANE;

    // Roughly 0.1 s at 33 MHz
    localparam int TICK_CYCLES_DEFAULT = 700 * 4096;

    // One colour bit for every chain
    typedef logic [NUM_LANES-1:0] lane_word_t;

    // Single-cycle requests from the button sampler
    typedef struct packed {
        logic color_step;
        logic demo_toggle;
    } pattern_cmd_t;

    // Pins of the LED panel connector
    typedef struct packed {
        logic       sclk;
        logic       latch;
        logic       blank;
        lane_word_t sdi;
    } panel_bus_t;

endpackage

`default_nettype wire

// ==== files.f ====
design/led_pkg.sv
design/button_sampler.sv
design/framebuffer_emulator.sv
design/driver_controller.sv
design/led_panel_top.sv
test/led_panel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the LED panel testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module led_panel_tb -Mdir obj_dir -f files.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vled_panel_tb > "$LOG" 2>&1
cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" && { echo "simulation reported a failure"; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"

// ==== test/led_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb import led_pkg::*; ();

    localparam int TICK         = 64;
    localparam int NUM_ROWS     = 9;
    localparam int FRAME_CYCLES = WORDS_PER_FRAME * (2 * GRAY_BITS + 1) + 1 + BLANK_CYCLES;

    // One stimulus row
    // Hold lengths are drawn at random for each press that is set
    typedef struct packed {
        logic       press_color;
        logic       press_demo;
        logic [3:0] frames;
        logic [1:0] color_sel;
        logic       demo_mode;
    } row_t;

    logic       clk_33;
    logic       nrst;
    logic       color_button;
    logic       demo_button;
    panel_bus_t panel;

    row_t table_rows [NUM_ROWS];
    int   color_hold [NUM_ROWS];
    int   demo_hold  [NUM_ROWS];

    int err_cnt;
    int rows_passed;
    int rows_failed;
    int cycle_cnt;
    int cycle_limit;
    // Posedges since reset release, mirrors the sampler tick counter
    int tick_pos;

    // Panel monitor state
    int                         ones_cnt [NUM_LANES];
    int                         gray_cnt;
    int                         word_cnt;
    int                         words_total;
    int                         frame_base;
    int                         frame_count;
    int                         last_base;
    int                         blank_len;
    logic                       in_blank;
    logic                       prev_latch;
    logic [WORDS_PER_FRAME-1:0] cur_words;
    logic [WORDS_PER_FRAME-1:0] last_words;

    led_panel_top #(
        .TICK_CYCLES (TICK)
    ) dut0 (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .color_button (color_button),
        .demo_button  (demo_button),
        .panel        (panel)
    );

    initial begin
        clk_33 = 1'b0;
        forever #5 clk_33 = !clk_33;
    end

    task automatic show_mismatch(input string name, input int expected, input int actual);
        $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        err_cnt++;
    endtask

    task automatic log_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        err_cnt++;
    endtask

    // Lit state of word w in a frame whose first LED has running index base
    function automatic logic expected_lit(input int w, input int base, input int color,
                                          input int demo);
        int bit_pos;
        int phase;
        int sel;
        bit_pos = w % NUM_COLORS;
        phase   = (base + w / NUM_COLORS) % NUM_COLORS;
        sel     = demo != 0 ? (phase + color) % NUM_COLORS : color;
        return bit_pos == sel;
    endfunction

    task automatic press_buttons(input int color_len, input int demo_len);
        int longest;
        int n;
        longest = (color_len > demo_len) ? color_len : demo_len;
        // Start so that the synchronised button rises right after a tick wrap
        while ((tick_pos % TICK) != TICK - 2) begin
            @(negedge clk_33);
        end
        color_button = (color_len > 0);
        demo_button  = (demo_len > 0);
        for (n = 1; n <= longest; n++) begin
            @(negedge clk_33);
            if (n == color_len) color_button = 1'b0;
            if (n == demo_len) demo_button = 1'b0;
        end
    endtask

    always @(posedge clk_33) begin
        cycle_cnt = cycle_cnt + 1;
        if (nrst) tick_pos = tick_pos + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Rebuilds words and frames from the serial pins
    always @(negedge clk_33) begin : monitor
        int l;
        int ref_ones;
        if (nrst) begin
            if (panel.sclk) begin
                if (in_blank) log_failure("sclk edge during blanking");
                for (l = 0; l < NUM_LANES; l++) begin
                    if (panel.sdi[l]) ones_cnt[l]++;
                end
                gray_cnt++;
                if (gray_cnt == GRAY_BITS) begin
                    ref_ones = ones_cnt[0];
                    for (l = 0; l < NUM_LANES; l++) begin
                        if (ones_cnt[l] != 0 && ones_cnt[l] != GRAY_BITS)
                            log_failure($sformatf("lane %0d word mixes ones and zeros", l));
                        if (ones_cnt[l] != ref_ones)
                            show_mismatch($sformatf("panel.sdi[%0d] ones", l), ref_ones,
                                          ones_cnt[l]);
                        ones_cnt[l] = 0;
                    end
                    if (word_cnt < WORDS_PER_FRAME) cur_words[word_cnt] = (ref_ones == GRAY_BITS);
                    word_cnt++;
                    words_total++;
                    gray_cnt = 0;
                end
            end
            if (panel.latch) begin
                if (prev_latch) log_failure("latch high for more than one cycle");
                if (word_cnt != WORDS_PER_FRAME) show_mismatch("words per frame",
                                                               WORDS_PER_FRAME, word_cnt);
                if (gray_cnt != 0) log_failure("latch arrived in the middle of a word");
                last_words  = cur_words;
                last_base   = frame_base;
                frame_base  = words_total / NUM_COLORS;
                word_cnt    = 0;
                in_blank    = 1'b1;
                blank_len   = 0;
                frame_count = frame_count + 1;
            end else if (in_blank) begin
                if (panel.blank) begin
                    blank_len++;
                end else begin
                    in_blank = 1'b0;
                    if (blank_len != BLANK_CYCLES) show_mismatch("panel.blank cycles",
                                                                 BLANK_CYCLES, blank_len);
                end
            end
            prev_latch = panel.latch;
        end
    end

    initial begin : stimulus
        int   seed_dummy;
        int   r;
        int   f;
        int   w;
        int   fc;
        int   row_err;
        logic exp_lit;
        row_t row;

        nrst         = 1'b0;
        color_button = 1'b0;
        demo_button  = 1'b0;
        err_cnt      = 0;
        rows_passed  = 0;
        rows_failed  = 0;
        cycle_cnt    = 0;
        tick_pos     = 0;
        gray_cnt     = 0;
        word_cnt     = 0;
        words_total  = 0;
        frame_base   = 0;
        frame_count  = 0;
        last_base    = 0;
        blank_len    = 0;
        in_blank     = 1'b0;
        prev_latch   = 1'b0;
        cur_words    = '0;
        last_words   = '0;
        for (r = 0; r < NUM_LANES; r++) ones_cnt[r] = 0;

        // press colour, press demo, frames, expected colour, expected demo
        table_rows[0] = '{1'b0, 1'b0, 4'd2, 2'd0, 1'b0};
        table_rows[1] = '{1'b1, 1'b0, 4'd2, 2'd1, 1'b0};
        table_rows[2] = '{1'b1, 1'b0, 4'd2, 2'd2, 1'b0};
        table_rows[3] = '{1'b1, 1'b0, 4'd2, 2'd0, 1'b0};
        table_rows[4] = '{1'b0, 1'b1, 4'd3, 2'd0, 1'b1};
        table_rows[5] = '{1'b1, 1'b0, 4'd3, 2'd1, 1'b1};
        table_rows[6] = '{1'b0, 1'b1, 4'd2, 2'd1, 1'b0};
        table_rows[7] = '{1'b1, 1'b1, 4'd3, 2'd2, 1'b1};
        table_rows[8] = '{1'b0, 1'b0, 4'd2, 2'd2, 1'b1};

        seed_dummy  = $urandom(32'he7b);
        cycle_limit = 1000;
        for (r = 0; r < NUM_ROWS; r++) begin
            color_hold[r] = table_rows[r].press_color ? TICK + 2 + int'($urandom % (TICK - 2)) : 0;
            demo_hold[r]  = table_rows[r].press_demo ? TICK + 2 + int'($urandom % (TICK - 2)) : 0;
            cycle_limit   = cycle_limit + FRAME_CYCLES * (int'(table_rows[r].frames) + 2)
                            + color_hold[r] + demo_hold[r];
        end

        repeat (5) @(negedge clk_33);
        // Idle panel while reset is held
        if (panel.blank !== 1'b1) show_mismatch("panel.blank", 1, int'(panel.blank));
        if (panel.sclk !== 1'b0) show_mismatch("panel.sclk", 0, int'(panel.sclk));
        if (panel.latch !== 1'b0) show_mismatch("panel.latch", 0, int'(panel.latch));
        if (panel.sdi !== '0) show_mismatch("panel.sdi", 0, int'(panel.sdi));
        nrst = 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            row     = table_rows[r];
            row_err = err_cnt;
            if (color_hold[r] > 0 || demo_hold[r] > 0) begin
                press_buttons(color_hold[r], demo_hold[r]);
                // Frame in flight may mix old and new pattern
                fc = frame_count;
                wait (frame_count > fc);
            end
            for (f = 0; f < int'(row.frames); f++) begin
                fc = frame_count;
                wait (frame_count > fc);
                for (w = 0; w < WORDS_PER_FRAME; w++) begin
                    exp_lit = expected_lit(w, last_base, int'(row.color_sel),
                                           int'(row.demo_mode));
                    if (last_words[w] !== exp_lit)
                        show_mismatch($sformatf("panel.sdi word %0d of frame %0d", w,
                                                frame_count), int'(exp_lit),
                                      int'(last_words[w]));
                end
            end
            if (err_cnt == row_err) begin
                rows_passed++;
                $display("row %0d ok: colour %0d demo %0d over %0d frames", r,
                         row.color_sel, row.demo_mode, row.frames);
            end else begin
                rows_failed++;
                $display("row %0d failed with %0d errors", r, err_cnt - row_err);
            end
        end

        // Let the last blanking interval be checked
        repeat (BLANK_CYCLES + 4) @(negedge clk_33);
        $display("rows passed %0d, rows failed %0d, errors %0d", rows_passed, rows_failed,
                 err_cnt);
        if (rows_failed == 0 && err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
